// File: logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // machine word, also used for immediates and addresses
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // major opcodes handled by the core
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_op_imm = 7'b0010011;
  localparam opcode_t op_op     = 7'b0110011;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_system = 7'b1110011;

  // alu funct3, shared by OP and OP-IMM
  localparam funct3_t f3_add  = 3'b000;
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_sr   = 3'b101;
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // branch funct3
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  localparam funct7_t f7_base = 7'b0000000;
  localparam funct7_t f7_alt  = 7'b0100000;

  typedef enum logic [3:0] {
    alu_pass_imm,
    alu_add,
    alu_sub,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_or,
    alu_and,
    alu_sll,
    alu_srl,
    alu_sra
  } alu_op_e;

  typedef enum logic [2:0] {
    bc_eq,
    bc_ne,
    bc_lt,
    bc_ge,
    bc_ltu,
    bc_geu
  } branch_cond_e;

  typedef enum logic {
    st_run,
    st_halted
  } core_state_e;

  // control and operands of the instruction in flight
  typedef struct packed {
    reg_idx_t     rd;
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    word_t        imm;
    alu_op_e      alu_op;
    logic         use_imm;
    logic         writes_rd;
    logic         is_branch;
    branch_cond_e branch_cond;
    logic         is_ecall;
    logic         illegal;
  } decoded_t;

  typedef struct packed {
    word_t    pc;
    reg_idx_t rd;
    word_t    rd_data;
    logic     writes_rd;
  } retire_t;

endpackage

`default_nettype wire

// File: logic/insn_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module insn_decoder import rv_pkg::*; (
  input  wire word_t insn,
  output decoded_t   dec
);

  opcode_t  opcode;
  funct3_t  funct3;
  funct7_t  funct7;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    imm_i;
  word_t    imm_b;
  word_t    imm_u;

  // base instruction fields
  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  // immediates, sign taken from bit 31
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  // same funct3 map for OP and OP-IMM, alt picks sub / sra
  function automatic alu_op_e alu_from_funct3(input funct3_t f3, input logic alt);
    alu_op_e op;
    case (f3)
      f3_add:  op = alt ? alu_sub : alu_add;
      f3_sll:  op = alu_sll;
      f3_slt:  op = alu_slt;
      f3_sltu: op = alu_sltu;
      f3_xor:  op = alu_xor;
      f3_sr:   op = alt ? alu_sra : alu_srl;
      f3_or:   op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  always_comb begin
    dec             = '0;
    dec.rs1         = rs1;
    dec.rs2         = rs2;
    dec.alu_op      = alu_add;
    dec.branch_cond = bc_eq;
    case (opcode)
      op_lui: begin
        dec.rd        = rd;
        dec.imm       = imm_u;
        dec.alu_op    = alu_pass_imm;
        dec.use_imm   = 1'b1;
        dec.writes_rd = 1'b1;
      end
      op_op_imm: begin
        dec.rd        = rd;
        dec.imm       = imm_i;
        dec.use_imm   = 1'b1;
        dec.writes_rd = 1'b1;
        // upper imm bits are funct7 only for the shifts
        dec.alu_op    = alu_from_funct3(funct3, (funct3 == f3_sr) && (funct7 == f7_alt));
        if (funct3 == f3_sll) begin
          dec.illegal = (funct7 != f7_base);
        end else if (funct3 == f3_sr) begin
          dec.illegal = (funct7 != f7_base) && (funct7 != f7_alt);
        end
      end
      op_op: begin
        dec.rd        = rd;
        dec.writes_rd = 1'b1;
        dec.alu_op    = alu_from_funct3(funct3, funct7 == f7_alt);
        // alt form exists only for sub and sra
        if (funct7 == f7_alt) begin
          dec.illegal = (funct3 != f3_add) && (funct3 != f3_sr);
        end else begin
          dec.illegal = (funct7 != f7_base);
        end
      end
      op_branch: begin
        dec.imm       = imm_b;
        dec.use_imm   = 1'b1;
        dec.is_branch = 1'b1;
        case (funct3)
          f3_beq:  dec.branch_cond = bc_eq;
          f3_bne:  dec.branch_cond = bc_ne;
          f3_blt:  dec.branch_cond = bc_lt;
          f3_bge:  dec.branch_cond = bc_ge;
          f3_bltu: dec.branch_cond = bc_ltu;
          f3_bgeu: dec.branch_cond = bc_geu;
          default: dec.illegal = 1'b1;
        endcase
      end
      op_system: begin
        // ecall only, every field above the opcode is zero
        dec.is_ecall = (insn[31:7] == 25'd0);
        dec.illegal  = !dec.is_ecall;
      end
      default: begin
        dec.illegal = 1'b1;
      end
    endcase
    if (dec.illegal) begin
      dec.rd        = '0;
      dec.writes_rd = 1'b0;
      dec.is_branch = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file import rv_pkg::*; (
  input  wire           clk,
  input  wire           rst,
  input  wire reg_idx_t rs1,
  input  wire reg_idx_t rs2,
  output word_t         rs1_data,
  output word_t         rs2_data,
  input  wire           we,
  input  wire reg_idx_t rd,
  input  wire word_t    rd_data
);

  localparam int num_regs = 32;

  word_t regs [num_regs];

  // x0 reads as zero no matter what
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import rv_pkg::*; (
  input  wire decoded_t dec,
  input  wire word_t    pc,
  input  wire word_t    rs1_data,
  input  wire word_t    rs2_data,
  output word_t         rd_value,
  output logic          branch_taken
);

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  logic       cond;

  // a branch runs pc + imm through the adder, giving its target
  assign op_a  = dec.is_branch ? pc : rs1_data;
  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      alu_pass_imm: rd_value = dec.imm;
      alu_add:      rd_value = op_a + op_b;
      alu_sub:      rd_value = op_a - op_b;
      alu_slt:      rd_value = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_sltu:     rd_value = {31'b0, op_a < op_b};
      alu_xor:      rd_value = op_a ^ op_b;
      alu_or:       rd_value = op_a | op_b;
      alu_and:      rd_value = op_a & op_b;
      alu_sll:      rd_value = op_a << shamt;
      alu_srl:      rd_value = op_a >> shamt;
      alu_sra:      rd_value = word_t'($signed(op_a) >>> shamt);
      default:      rd_value = op_a + op_b;
    endcase
  end

  // compare on the register values, never on the immediate
  always_comb begin
    case (dec.branch_cond)
      bc_eq:   cond = (rs1_data == rs2_data);
      bc_ne:   cond = (rs1_data != rs2_data);
      bc_lt:   cond = ($signed(rs1_data) < $signed(rs2_data));
      bc_ge:   cond = ($signed(rs1_data) >= $signed(rs2_data));
      bc_ltu:  cond = (rs1_data < rs2_data);
      bc_geu:  cond = (rs1_data >= rs2_data);
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken = dec.is_branch && cond;

endmodule

`default_nettype wire

// File: logic/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit import rv_pkg::*; #(
  parameter word_t reset_pc = '0
) (
  input  wire           clk,
  input  wire           rst,
  input  wire decoded_t dec,
  input  wire           branch_taken,
  input  wire word_t    rd_value,
  output word_t         pc,
  output word_t         fetch_pc,
  output logic          reg_we,
  output logic          retire_valid,
  output retire_t       retire,
  output logic          halt,
  output logic          illegal
);

  core_state_e state;
  logic        running;
  logic        commit;
  logic        illegal_q;

  assign running = (state == st_run);

  // insn only belongs to pc once reset is released
  assign commit       = running && !rst && !dec.illegal;
  assign retire_valid = commit;
  assign reg_we       = commit && dec.writes_rd;

  // fetch address doubles as next pc; rd_value holds the branch target
  always_comb begin
    if (rst) begin
      fetch_pc = reset_pc;
    end else if (!running) begin
      fetch_pc = pc;
    end else if (branch_taken) begin
      fetch_pc = rd_value;
    end else begin
      fetch_pc = pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc        <= reset_pc;
      state     <= st_run;
      illegal_q <= 1'b0;
    end else begin
      pc <= fetch_pc;
      if (running && (dec.is_ecall || dec.illegal)) begin
        state <= st_halted;
      end
      // sticky until the next reset
      if (running && dec.illegal) begin
        illegal_q <= 1'b1;
      end
    end
  end

  assign halt    = (state == st_halted);
  assign illegal = illegal_q;

  assign retire = '{pc: pc, rd: dec.rd, rd_data: rd_value, writes_rd: dec.writes_rd};

endmodule

`default_nettype wire

// File: logic/rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core import rv_pkg::*; #(
  parameter word_t reset_pc = '0
) (
  input  wire        clk,
  input  wire        rst,
  output word_t      fetch_pc,
  input  wire word_t insn,
  output logic       retire_valid,
  output retire_t    retire,
  output logic       halt,
  output logic       illegal
);

  decoded_t dec;
  word_t    pc;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    rd_value;
  logic     branch_taken;
  logic     reg_we;

  insn_decoder u_decoder (
    .insn (insn),
    .dec  (dec)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (reg_we),
    .rd       (dec.rd),
    .rd_data  (rd_value)
  );

  alu u_alu (
    .dec          (dec),
    .pc           (pc),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .rd_value     (rd_value),
    .branch_taken (branch_taken)
  );

  // pc, run/halt state and retire port
  fetch_unit #(
    .reset_pc (reset_pc)
  ) u_fetch (
    .clk          (clk),
    .rst          (rst),
    .dec          (dec),
    .branch_taken (branch_taken),
    .rd_value     (rd_value),
    .pc           (pc),
    .fetch_pc     (fetch_pc),
    .reg_we       (reg_we),
    .retire_valid (retire_valid),
    .retire       (retire),
    .halt         (halt),
    .illegal      (illegal)
  );

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int reset_cycles = 8
) (
  input  wire  restart,
  output logic clk,
  output logic rst
);

  int count = 0;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial rst = 1'b1;

  // restart raises rst again for another full reset
  always @(posedge clk) begin
    if (restart) begin
      rst   <= 1'b1;
      count <= 0;
    end else if (rst) begin
      count <= count + 1;
      if (count == reset_cycles - 1) begin
        rst <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;
  import rv_pkg::*;

  localparam logic [6:0] opc_lui = 7'b0110111;
  localparam logic [6:0] opc_imm = 7'b0010011;
  localparam logic [6:0] opc_reg = 7'b0110011;
  localparam logic [6:0] opc_brn = 7'b1100011;
  localparam logic [6:0] opc_load = 7'b0000011;
  localparam word_t ecall_word = 32'h0000_0073;

  logic    clk;
  logic    rst;
  logic    restart;
  word_t   fetch_pc;
  word_t   insn;
  logic    retire_valid;
  retire_t retire;
  logic    halt;
  logic    illegal;

  word_t imem [256];
  word_t shadow [32];
  word_t exp_pc;
  word_t last_insn;
  word_t frozen_pc;
  int    retire_count;
  int    errors;
  int    cycles;

  tb_clock_gen clock_gen (.restart(restart), .clk(clk), .rst(rst));

  rv_core #(.reset_pc(32'd0)) UUT (
    .clk(clk), .rst(rst), .fetch_pc(fetch_pc), .insn(insn),
    .retire_valid(retire_valid), .retire(retire), .halt(halt), .illegal(illegal)
  );

  // synchronous instruction port
  always @(posedge clk) begin
    insn <= imem[fetch_pc[9:2]];
  end

  function automatic word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                  input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opc_reg};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input int rs1, input logic [2:0] f3,
                                  input int rd, input logic [6:0] opc);
    return {imm, rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic word_t enc_b(input logic [12:0] off, input int rs2, input int rs1,
                                  input logic [2:0] f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], opc_brn};
  endfunction

  // expected results straight from the RV32I definitions
  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a,
                                    input word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic taken_ref(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic ref_exec(input word_t ins, input word_t pc, output logic wr, output word_t val,
                          output word_t npc);
    word_t a;
    word_t b;
    a   = shadow[ins[19:15]];
    b   = shadow[ins[24:20]];
    wr  = 1'b0;
    val = '0;
    npc = pc + 32'd4;
    case (ins[6:0])
      opc_lui: begin
        wr  = 1'b1;
        val = {ins[31:12], 12'b0};
      end
      opc_imm: begin
        wr  = 1'b1;
        val = alu_ref(ins[14:12], ins[30] && (ins[14:12] == 3'd5), a,
                      {{20{ins[31]}}, ins[31:20]});
      end
      opc_reg: begin
        wr  = 1'b1;
        val = alu_ref(ins[14:12], ins[30], a, b);
      end
      opc_brn: begin
        if (taken_ref(ins[14:12], a, b)) begin
          npc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      default: ;
    endcase
  endtask

  task automatic flag_mismatch(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic put(inout int n, input word_t w);
    imem[n] = w;
    n++;
  endtask

  task automatic fill_memory();
    // unused words carry opcode zero, so they decode as illegal
    for (int i = 0; i < 256; i++) begin
      imem[i] = {i[24:0], 7'b0};
    end
  endtask

  task automatic build_main_program();
    int    n;
    word_t v;
    int    f3s [6];
    f3s = '{0, 1, 4, 5, 6, 7};
    n   = 0;
    fill_memory();
    for (int r = 1; r <= 8; r++) begin
      v = $urandom;
      put(n, {v[31:12], r[4:0], opc_lui});
      put(n, enc_i(v[11:0], r, 3'd0, r, opc_imm));
    end
    for (int f = 0; f < 8; f++) begin
      v = $urandom;
      if (f == 1 || f == 5) v[11:5] = 7'b0;
      put(n, enc_i(v[11:0], 1 + ($urandom % 8), f[2:0], 9 + f, opc_imm));
    end
    v = $urandom;
    put(n, enc_i({7'b0100000, v[4:0]}, 1 + ($urandom % 8), 3'd5, 17, opc_imm));
    for (int f = 0; f < 8; f++) begin
      put(n, enc_r(7'b0, 1 + ($urandom % 17), 1 + ($urandom % 17), f[2:0], 18 + f));
    end
    put(n, enc_r(7'b0100000, 2, 1, 3'd0, 26));
    put(n, enc_r(7'b0100000, 9, 3, 3'd5, 27));
    // write to x0, then read it back
    put(n, enc_r(7'b0, 2, 1, 3'd0, 0));
    put(n, enc_r(7'b0, 0, 0, 3'd0, 28));
    put(n, enc_r(7'b0, 1, 0, 3'd6, 29));
    for (int i = 0; i < 6; i++) begin
      put(n, enc_b(13'd8, 1, 1, f3s[i][2:0]));
      put(n, enc_i(12'd1, 0, 3'd0, 30, opc_imm));
      put(n, enc_b(13'd8, 2, 1, f3s[i][2:0]));
      put(n, enc_i(12'd2, 0, 3'd0, 30, opc_imm));
      put(n, enc_b(13'd8, 1, 2, f3s[i][2:0]));
      put(n, enc_i(12'd3, 0, 3'd0, 30, opc_imm));
    end
    put(n, ecall_word);
  endtask

  task automatic build_illegal_program();
    int n;
    n = 0;
    fill_memory();
    put(n, enc_i(12'd5, 0, 3'd0, 1, opc_imm));
    put(n, enc_i(12'd0, 1, 3'd2, 2, opc_load));
    put(n, enc_i(12'd7, 0, 3'd0, 3, opc_imm));
    put(n, ecall_word);
  endtask

  // reference model, advances on every retire
  always @(negedge clk) begin
    logic  wr;
    word_t val;
    word_t npc;
    word_t ins;
    if (rst) begin
      exp_pc       = '0;
      retire_count = 0;
      for (int i = 0; i < 32; i++) shadow[i] = '0;
    end else if (retire_valid) begin
      ins = imem[exp_pc[9:2]];
      assert (retire.pc == exp_pc)
        else flag_mismatch($sformatf("retire pc %h, expected %h", retire.pc, exp_pc));
      ref_exec(ins, exp_pc, wr, val, npc);
      assert (retire.writes_rd == wr)
        else flag_mismatch($sformatf("writes_rd wrong at pc %h", exp_pc));
      if (wr) begin
        assert (retire.rd == ins[11:7] && retire.rd_data == val)
          else flag_mismatch($sformatf("pc %h rd x%0d data %h, expected x%0d %h", exp_pc,
                                       retire.rd, retire.rd_data, ins[11:7], val));
        if (ins[11:7] != 5'd0) shadow[ins[11:7]] = val;
      end
      last_insn = ins;
      exp_pc    = npc;
      retire_count++;
    end
  end

  task automatic give_up(input string what);
    $display("timeout while waiting for %s", what);
    $display("errors: %0d wrong values, 1 timeout", errors);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic wait_for_rst(input logic level, input string what);
    cycles = 0;
    while (rst != level && cycles < 50) begin
      @(negedge clk);
      cycles++;
    end
    if (rst != level) give_up(what);
  endtask

  task automatic wait_for_halt(input string what);
    cycles = 0;
    while (!halt && cycles < 500) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) give_up(what);
  endtask

  task automatic check_quiet_halt();
    frozen_pc = fetch_pc;
    repeat (20) begin
      @(negedge clk);
      assert (!retire_valid && halt && fetch_pc == frozen_pc)
        else flag_mismatch("core not frozen while halted");
    end
  endtask

  initial begin
    void'($urandom(32'h02db_292a));
    errors   = 0;
    restart  = 1'b0;
    insn     = '0;
    build_main_program();

    // reset behavior
    cycles = 0;
    while (rst && cycles < 50) begin
      @(negedge clk);
      cycles++;
      if (rst) begin
        assert (!retire_valid && !halt && !illegal) else flag_mismatch("outputs active in reset");
      end
    end
    if (rst) give_up("end of first reset");
    assert (!halt && !illegal) else flag_mismatch("halt or illegal after reset");

    // immediate, register and branch groups, then ECALL
    wait_for_halt("ECALL halt");
    // one retire in every cycle up to the ECALL
    assert (last_insn == ecall_word && !illegal && retire_count == cycles)
      else flag_mismatch($sformatf("halt after %0d retires in %0d cycles, last insn %h",
                                   retire_count, cycles, last_insn));
    check_quiet_halt();

    // second reset with an illegal load
    build_illegal_program();
    @(posedge clk);
    restart <= 1'b1;
    @(posedge clk);
    restart <= 1'b0;
    wait_for_rst(1'b1, "second reset");
    wait_for_rst(1'b0, "end of second reset");
    wait_for_halt("illegal halt");
    assert (illegal && retire_count == 1)
      else flag_mismatch($sformatf("illegal %0b after %0d retires", illegal, retire_count));
    check_quiet_halt();

    $display("errors: %0d wrong values, 0 timeouts", errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
logic/rv_pkg.sv
logic/insn_decoder.sv
logic/reg_file.sv
logic/alu.sv
logic/fetch_unit.sv
logic/rv_core.sv
sim/tb_clock_gen.sv
sim/tb_rv_core.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing
TOP      = tb_rv_core
FILELIST = all.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "test failed"; exit 1; \
	fi
	@grep -q "Simulation passed" $(LOG) || (echo "no result in log"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
